/* filelist.f */
logic/mipsPkg.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/alu.sv
logic/dataMem.sv
logic/controller.sv
logic/mipsCore.sv
tests/mipsTb.sv

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import mipsPkg::*; (
    input  aluOp_t     aluOp,
    input  word_t      x,
    input  word_t      y,
    input  logic [4:0] shamt,
    output word_t      result,
    output logic       zero
);

    always_comb begin
        case (aluOp)
            AluAdd: begin
                result = x + y;
            end
            AluSub: begin
                result = x - y;
            end
            AluAnd: begin
                result = x & y;
            end
            AluOr: begin
                result = x | y;
            end
            AluSlt: begin
                // signed compare
                result = {31'b0, $signed(x) < $signed(y)};
            end
            AluSll: begin
                result = y << shamt;
            end
            AluLui: begin
                result = {y[15:0], 16'h0000};
            end
            default: begin
                result = x + y;
            end
        endcase
    end

    // Used by beq after a subtract
    assign zero = (result == '0);

endmodule

/* logic/controller.sv */
`timescale 1ns/1ps

module controller import mipsPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic       zero,
    output logic       pcWr,
    output logic       irWr,
    output logic       regWr,
    output logic       memWr,
    output logic       aluOWr,
    output npcSel_t    npcSel,
    output regDst_t    regDst,
    output wbSel_t     wbSel,
    output logic       aluSrc,
    output extOp_t     extOp,
    output aluOp_t     aluOp,
    output logic       byteAcc
);

    ctrlState_t state, nextState;

    logic isRType, isJr, isImm, isLoad, isStore;
    logic isBeq, isJ, isJal;

    // Instruction classes
    assign isRType = (opcode == OpRType) && (funct != FnJr);
    assign isJr    = (opcode == OpRType) && (funct == FnJr);
    assign isImm   = (opcode == OpAddiu) || (opcode == OpOri) || (opcode == OpLui);
    assign isLoad  = (opcode == OpLw) || (opcode == OpLb);
    assign isStore = (opcode == OpSw) || (opcode == OpSb);
    assign isBeq   = (opcode == OpBeq);
    assign isJ     = (opcode == OpJ);
    assign isJal   = (opcode == OpJal);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= StFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            StFetch:  nextState = StDecode;
            StDecode: nextState = StExec;
            StExec: begin
                if (isLoad || isStore) begin
                    nextState = StMem;
                end else if (isRType || isImm) begin
                    nextState = StWb;
                end else begin
                    // branches, jumps and unknown opcodes end here
                    nextState = StFetch;
                end
            end
            StMem:    nextState = isLoad ? StWb : StFetch;
            default:  nextState = StFetch;
        endcase
    end

    // Strobes
    assign irWr   = (state == StFetch);
    assign pcWr   = (state == StFetch) ||
                    ((state == StExec) && (isJ || isJal || isJr || (isBeq && zero)));
    assign aluOWr = (state == StExec);
    assign memWr  = (state == StMem) && isStore;
    // Only ALU and load instructions reach StWb
    assign regWr  = (state == StWb) || ((state == StExec) && isJal);

    // Selects decoded from the current instruction
    always_comb begin
        npcSel = NpcSeq;
        if (state == StExec) begin
            if (isBeq) begin
                npcSel = NpcBranch;
            end else if (isJ || isJal) begin
                npcSel = NpcJump;
            end else if (isJr) begin
                npcSel = NpcReg;
            end
        end
    end

    assign regDst  = isRType ? DstRd : (isJal ? DstRet : DstRt);
    assign wbSel   = isLoad ? WbMem : (isJal ? WbPc : WbAlu);
    assign aluSrc  = isImm || isLoad || isStore;
    assign extOp   = (opcode == OpOri || opcode == OpLui) ? ExtZero : ExtSign;
    assign byteAcc = (opcode == OpLb) || (opcode == OpSb);

    always_comb begin
        aluOp = AluAdd;
        if (isRType) begin
            case (funct)
                FnSubu:  aluOp = AluSub;
                FnAnd:   aluOp = AluAnd;
                FnOr:    aluOp = AluOr;
                FnSlt:   aluOp = AluSlt;
                FnSll:   aluOp = AluSll;
                default: aluOp = AluAdd;
            endcase
        end else if (isBeq) begin
            aluOp = AluSub;
        end else if (opcode == OpOri) begin
            aluOp = AluOr;
        end else if (opcode == OpLui) begin
            aluOp = AluLui;
        end
    end

    // The store follows the address cycle in StExec
    memWrInMem: assert property (@(posedge clk) disable iff (!rstN)
        memWr |-> $past(state) == StExec)
        else $error("memory write not directly after StExec");

    // Fetch and write-back never overlap
    oneWriter: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({irWr, regWr, memWr}))
        else $error("irWr, regWr and memWr overlap");

endmodule

/* logic/dataMem.sv */
`timescale 1ns/1ps

module dataMem import mipsPkg::*; (
    input  logic                   clk,
    input  logic                   we,
    input  logic                   byteAcc,
    input  logic [DmAddrWidth-1:0] addr,
    input  word_t                  wrData,
    output word_t                  rdData
);

    localparam int Bytes = 1 << DmAddrWidth;

    logic [7:0] mem [Bytes];

    logic [DmAddrWidth-1:0] wordBase;
    logic [7:0]             rdByte;
    word_t                  rdWord;

    assign wordBase = {addr[DmAddrWidth-1:2], 2'b00};

    // Little endian with the low byte at the lowest address
    assign rdWord = {mem[wordBase + 3], mem[wordBase + 2],
                     mem[wordBase + 1], mem[wordBase]};
    assign rdByte = mem[addr];

    assign rdData = byteAcc ? {{24{rdByte[7]}}, rdByte} : rdWord;

    always_ff @(posedge clk) begin
        if (we) begin
            if (byteAcc) begin
                mem[addr] <= wrData[7:0];
            end else begin
                mem[wordBase]     <= wrData[7:0];
                mem[wordBase + 1] <= wrData[15:8];
                mem[wordBase + 2] <= wrData[23:16];
                mem[wordBase + 3] <= wrData[31:24];
            end
        end
    end

    wordAligned: assert property (@(posedge clk) (we && !byteAcc) |-> addr[1:0] == 2'b00)
        else $error("unaligned word store at %h", addr);

endmodule

/* logic/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        pcWr,
    input  logic        irWr,
    input  npcSel_t     npcSel,
    input  word_t       branchOff,
    input  logic [25:0] jumpTarget,
    input  word_t       regTarget,
    input  word_t       instr,
    output word_t       pc,
    output word_t       ir
);

    word_t nextPc;

    // By StExec the PC already holds PC+4 of the current instruction
    always_comb begin
        case (npcSel)
            NpcBranch: nextPc = pc + branchOff;
            NpcJump:   nextPc = {pc[31:28], jumpTarget, 2'b00};
            NpcReg:    nextPc = regTarget;
            default:   nextPc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= ResetPc;
        end else if (pcWr) begin
            pc <= nextPc;
        end
    end

    // Instruction register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ir <= '0;
        end else if (irWr) begin
            ir <= instr;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

/* logic/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    output word_t    instrAddr,
    input  word_t    instr,
    output logic     wbEn,
    output regAddr_t wbAddr,
    output word_t    wbData,
    output logic     storeEn,
    output word_t    storeAddr,
    output word_t    storeData
);

    // Controller strobes and selects
    logic    pcWr, irWr, regWr, memWr, aluOWr;
    logic    aluSrc, byteAcc, zero;
    npcSel_t npcSel;
    regDst_t regDst;
    wbSel_t  wbSel;
    extOp_t  extOp;
    aluOp_t  aluOp;

    word_t    pc, ir;
    regAddr_t rs, rt, rd, wrAddr;
    word_t    rdDataA, rdDataB, aluY, aluResult, memRdData;
    word_t    extOut, wrData;

    // Registers between cycles
    word_t regA, regB, aluOut, drReg;

    assign rs = ir[25:21];
    assign rt = ir[20:16];
    assign rd = ir[15:11];

    fetchUnit ifu (
        .clk(clk), .rstN(rstN), .pcWr(pcWr), .irWr(irWr), .npcSel(npcSel),
        .branchOff({extOut[29:0], 2'b00}), .jumpTarget(ir[25:0]),
        .regTarget(regA), .instr(instr), .pc(pc), .ir(ir)
    );

    regFile gpr (
        .clk(clk), .rstN(rstN), .we(regWr), .rdAddrA(rs), .rdAddrB(rt),
        .wrAddr(wrAddr), .wrData(wrData), .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    alu aluUnit (
        .aluOp(aluOp), .x(regA), .y(aluY), .shamt(ir[10:6]),
        .result(aluResult), .zero(zero)
    );

    dataMem dm (
        .clk(clk), .we(memWr), .byteAcc(byteAcc), .addr(aluOut[DmAddrWidth-1:0]),
        .wrData(regB), .rdData(memRdData)
    );

    controller ctrl (
        .clk(clk), .rstN(rstN), .opcode(ir[31:26]), .funct(ir[5:0]), .zero(zero),
        .pcWr(pcWr), .irWr(irWr), .regWr(regWr), .memWr(memWr), .aluOWr(aluOWr),
        .npcSel(npcSel), .regDst(regDst), .wbSel(wbSel), .aluSrc(aluSrc),
        .extOp(extOp), .aluOp(aluOp), .byteAcc(byteAcc)
    );

    // A, B and DR sample every cycle; DR is consumed in the StWb after StMem
    always_ff @(posedge clk) begin
        regA  <= rdDataA;
        regB  <= rdDataB;
        drReg <= memRdData;
        if (aluOWr) begin
            aluOut <= aluResult;
        end
    end

    // Immediate extender
    always_comb begin
        case (extOp)
            ExtSign: extOut = {{16{ir[15]}}, ir[15:0]};
            default: extOut = {16'h0000, ir[15:0]};
        endcase
    end

    assign aluY = aluSrc ? extOut : regB;

    always_comb begin
        case (regDst)
            DstRd:   wrAddr = rd;
            DstRet:  wrAddr = RegRet;
            default: wrAddr = rt;
        endcase
    end

    // jal writes in StExec, when pc already holds its address plus 4
    always_comb begin
        case (wbSel)
            WbMem:   wrData = drReg;
            WbPc:    wrData = pc;
            default: wrData = aluOut;
        endcase
    end

    assign instrAddr = pc;

    // Observation ports
    assign wbEn      = regWr;
    assign wbAddr    = wrAddr;
    assign wbData    = wrData;
    assign storeEn   = memWr;
    assign storeAddr = aluOut;
    assign storeData = regB;

endmodule

/* logic/mipsPkg.sv */
package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    localparam regAddr_t RegRet = 5'd31;
    localparam int DmAddrWidth = 10;
    localparam word_t ResetPc = 32'h0000_0000;

    // Primary opcodes in ir[31:26]
    localparam logic [5:0] OpRType = 6'h00;
    localparam logic [5:0] OpJ     = 6'h02;
    localparam logic [5:0] OpJal   = 6'h03;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpAddiu = 6'h09;
    localparam logic [5:0] OpOri   = 6'h0d;
    localparam logic [5:0] OpLui   = 6'h0f;
    localparam logic [5:0] OpLb    = 6'h20;
    localparam logic [5:0] OpLw    = 6'h23;
    localparam logic [5:0] OpSb    = 6'h28;
    localparam logic [5:0] OpSw    = 6'h2b;

    // R-type function codes in ir[5:0]
    localparam logic [5:0] FnSll  = 6'h00;
    localparam logic [5:0] FnJr   = 6'h08;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnSlt  = 6'h2a;

    typedef enum logic [2:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluSlt, AluSll, AluLui
    } aluOp_t;

    // Next PC source
    typedef enum logic [1:0] {
        NpcSeq, NpcBranch, NpcJump, NpcReg
    } npcSel_t;

    typedef enum logic [1:0] {
        DstRt, DstRd, DstRet
    } regDst_t;

    typedef enum logic [1:0] {
        WbAlu, WbMem, WbPc
    } wbSel_t;

    typedef enum logic [1:0] {
        ExtZero, ExtSign, ExtHigh
    } extOp_t;

    typedef enum logic [2:0] {
        StFetch, StDecode, StExec, StMem, StWb
    } ctrlState_t;

endpackage

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     we,
    input  regAddr_t rdAddrA,
    input  regAddr_t rdAddrB,
    input  regAddr_t wrAddr,
    input  word_t    wrData,
    output word_t    rdDataA,
    output word_t    rdDataB
);

    word_t regs [32];

    // Register 0 is cleared by reset and never written afterwards
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Asynchronous reads
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    wrAddrKnown: assert property (@(posedge clk) disable iff (!rstN)
        we |-> !$isunknown(wrAddr))
        else $error("register write with unknown address");

endmodule

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the MIPS core testbench from the project root
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module mipsTb -f filelist.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q -F '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tests/mipsTb.sv */
`timescale 1ns/1ps

module mipsTb import mipsPkg::*; ();

    localparam int MaxCycles = 1000;

    logic     clk;
    logic     rstN;
    word_t    instrAddr;
    word_t    instr;
    logic     wbEn;
    regAddr_t wbAddr;
    word_t    wbData;
    logic     storeEn;
    word_t    storeAddr;
    word_t    storeData;

    // Program words by byte address
    word_t imem [word_t];

    // Expected traces in program order
    regAddr_t expWbAddr [$];
    word_t    expWbData [$];
    word_t    expStAddr [$];
    word_t    expStData [$];
    logic     expStByte [$];

    mipsCore UUT (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData)
    );

    always #50 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic loadStim();
        int         fd;
        int         n;
        int         c;
        int         regNum;
        int         isByte;
        logic [7:0] tag;
        word_t      addr;
        word_t      value;
        fd = $fopen("tests/progStim.txt", "r");
        if (fd == 0) begin
            abortRun("Cannot open tests/progStim.txt");
        end else begin
            n = $fscanf(fd, "%s", tag);
            while (n == 1) begin
                if (tag == "P") begin
                    n = $fscanf(fd, "%h %h", addr, value);
                    imem[addr] = value;
                end else if (tag == "W") begin
                    n = $fscanf(fd, "%d %h", regNum, value);
                    expWbAddr.push_back(regAddr_t'(regNum));
                    expWbData.push_back(value);
                end else if (tag == "S") begin
                    n = $fscanf(fd, "%h %h %d", addr, value, isByte);
                    expStAddr.push_back(addr);
                    expStData.push_back(value);
                    expStByte.push_back(isByte != 0);
                end else begin
                    // Skip the rest of a comment line
                    c = $fgetc(fd);
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
                n = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
    endtask

    task automatic checkWriteBack();
        regAddr_t expAddr;
        word_t    expData;
        if (expWbAddr.size() == 0) begin
            abortRun($sformatf("Unexpected register write to r%0d at %0t ns", wbAddr, $time));
        end else begin
            expAddr = expWbAddr.pop_front();
            expData = expWbData.pop_front();
            assert (wbAddr == expAddr)
                else abortRun($sformatf("Error at %0t ns: wbAddr expected %0d, actual %0d",
                                        $time, expAddr, wbAddr));
            assert (wbData == expData)
                else abortRun($sformatf("Error at %0t ns: wbData expected %h, actual %h",
                                        $time, expData, wbData));
        end
    endtask

    task automatic checkStore();
        word_t expAddr;
        word_t expData;
        word_t mask;
        if (expStAddr.size() == 0) begin
            abortRun($sformatf("Unexpected store to %h at %0t ns", storeAddr, $time));
        end else begin
            expAddr = expStAddr.pop_front();
            expData = expStData.pop_front();
            // A byte store only commits the low byte
            mask = expStByte.pop_front() ? 32'h0000_00ff : 32'hffff_ffff;
            assert (storeAddr == expAddr)
                else abortRun($sformatf("Error at %0t ns: storeAddr expected %h, actual %h",
                                        $time, expAddr, storeAddr));
            assert ((storeData & mask) == (expData & mask))
                else abortRun($sformatf("Error at %0t ns: storeData expected %h, actual %h",
                                        $time, expData & mask, storeData & mask));
        end
    endtask

    // Instruction memory follows the PC on the falling edge
    always @(negedge clk) begin
        if (imem.exists(instrAddr)) begin
            instr = imem[instrAddr];
        end else begin
            // Unloaded words read as sll r0, which shows up as an extra write
            instr = '0;
        end
    end

    initial begin
        int cycles;
        clk   = 1'b0;
        rstN  = 1'b0;
        instr = '0;
        loadStim();
        // Three rising edges in reset
        repeat (3) begin
            @(negedge clk);
            assert (!wbEn && !storeEn)
                else abortRun("Write-back or store strobe active during reset");
        end
        rstN = 1'b1;
        assert (instrAddr == ResetPc)
            else abortRun($sformatf("Error at %0t ns: instrAddr expected %h, actual %h",
                                    $time, ResetPc, instrAddr));
        cycles = 0;
        while ((expWbAddr.size() != 0 || expStAddr.size() != 0) && cycles < MaxCycles) begin
            @(negedge clk);
            cycles++;
            if (wbEn) begin
                checkWriteBack();
            end
            if (storeEn) begin
                checkStore();
            end
        end
        if (expWbAddr.size() == 0 && expStAddr.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            abortRun($sformatf("The program did not finish within %0d cycles", MaxCycles));
        end
    end

endmodule

/* tests/progStim.txt */
# P byteAddr word | W reg(dec) value | S byteAddr value byteStore(0/1)
# Addresses, words and values in hex; W and S lines in program order
P 00000000 24010005
P 00000004 2402FFFD
P 00000008 00221821
P 0000000C 00412023
P 00000010 00222824
P 00000014 00223025
P 00000018 0041382A
P 0000001C 0024402A
P 00000020 00014900
P 00000024 340A8001
P 00000028 3C0B1234
P 0000002C 24200007
P 00000030 00016021
P 00000034 240D0080
P 00000038 AC0B0010
P 0000003C A00D0014
P 00000040 8C0E0010
P 00000044 800F0014
P 00000048 102C0001
P 0000004C 24100BAD
P 00000050 10220001
P 00000054 24100001
P 00000058 08000018
P 0000005C 24110BAD
P 00000060 0C00001C
P 00000064 24120002
P 00000068 0800001A
P 00000070 24130003
P 00000074 03E00008
W 1 00000005
W 2 FFFFFFFD
W 3 00000002
W 4 FFFFFFF8
W 5 00000005
W 6 FFFFFFFD
W 7 00000001
W 8 00000000
W 9 00000050
W 10 00008001
W 11 12340000
W 0 0000000C
W 12 00000005
W 13 00000080
S 00000010 12340000 0
S 00000014 00000080 1
W 14 12340000
W 15 FFFFFF80
W 16 00000001
W 31 00000064
W 19 00000003
W 18 00000002
